// File: bios.hex
// bios words 0 to 15, one 32-bit hex word per line
3C1A1F80
375A1000
8F5B0000
00000000
3C08BFC0
25080180
01000008
00000000
24090001
AD090000
1000FFFF
00000000
3C0B0000
356B0F00
016B6021
03E00008

// File: list.f
mem_map_pkg.sv
bios_rom.sv
main_ram.sv
scratch_pad.sv
hw_regs.sv
bus_decoder.sv
mem_system.sv
mem_system_tb.sv

// File: Bender.yml
package:
  name: mem_system

sources:
  - mem_map_pkg.sv
  - bios_rom.sv
  - main_ram.sv
  - scratch_pad.sv
  - hw_regs.sv
  - bus_decoder.sv
  - mem_system.sv
  - target: simulation
    files:
      - mem_system_tb.sv

// File: mem_system_tb.sv
`timescale 1ns/1ps

module mem_system_tb;
   import mem_map_pkg::*;

   localparam int CLK_PERIOD = 100;
   localparam int N_RANDOM   = 300;
   localparam int N_ACCESS   = 134 + N_RANDOM;  // directed plus random

   logic        clk;
   logic        rst;
   cpu_req_t    cpu_req;
   logic        ack;
   logic [31:0] rdata;

   logic [31:0] bios_m [BIOS_WORDS];  // shadow copies of every target
   logic [31:0] main_m [MAIN_WORDS];
   logic [31:0] scpad_m [SCPAD_WORDS];
   logic [31:0] hw_m [HWREG_WORDS];

   string       exp_name;
   logic [31:0] exp_data;
   logic        exp_pend;

   mem_system dut0 (
      .clk     (clk),
      .rst     (rst),
      .cpu_i   (cpu_req),
      .ack_o   (ack),
      .rdata_o (rdata)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   function automatic logic in_range(logic [31:0] a, logic [31:0] base, logic [31:0] size);
      return (a >= base) && (a <= base + (size - 1));
   endfunction

   function automatic region_e region_of(logic [31:0] a);
      if (in_range(a, BIOS_BASE_0, BIOS_SIZE) || in_range(a, BIOS_BASE_1, BIOS_SIZE) ||
          in_range(a, BIOS_BASE_2, BIOS_SIZE)) begin
         return REG_BIOS;
      end
      if (in_range(a, MAIN_BASE_0, MAIN_SIZE) || in_range(a, MAIN_BASE_1, MAIN_SIZE) ||
          in_range(a, MAIN_BASE_2, MAIN_SIZE)) begin
         return REG_MAIN;
      end
      if (in_range(a, SCPAD_BASE_0, SCPAD_SIZE) || in_range(a, SCPAD_BASE_1, SCPAD_SIZE)) begin
         return REG_SCPAD;
      end
      if (in_range(a, HWREG_BASE_0, HWREG_SIZE) || in_range(a, HWREG_BASE_1, HWREG_SIZE) ||
          in_range(a, HWREG_BASE_2, HWREG_SIZE) || a == MEM_CTRL_3) begin
         return REG_HWREG;
      end
      return REG_NONE;
   endfunction

   function automatic logic [31:0] ref_read(logic [31:0] a);
      case (region_of(a))
         REG_BIOS:  return bios_m[a[31:2] % BIOS_WORDS];
         REG_MAIN:  return main_m[a[31:2] % MAIN_WORDS];
         REG_SCPAD: return scpad_m[a[31:2] % SCPAD_WORDS];
         REG_HWREG: return hw_m[a[31:2] % HWREG_WORDS];
         default:   return 32'h0;  // unmapped reads as zero
      endcase
   endfunction

   function automatic void ref_write(logic [31:0] a, logic [31:0] d);
      case (region_of(a))
         REG_MAIN:  main_m[a[31:2] % MAIN_WORDS] = d;
         REG_SCPAD: scpad_m[a[31:2] % SCPAD_WORDS] = d;
         REG_HWREG: hw_m[a[31:2] % HWREG_WORDS] = d;
         default:   ;  // rom and unmapped writes vanish
      endcase
   endfunction

   function automatic logic [31:0] pick3(int m, logic [31:0] b0, logic [31:0] b1,
                                         logic [31:0] b2);
      case (m % 3)
         0:       return b0;
         1:       return b1;
         default: return b2;
      endcase
   endfunction

   // k picks an alias window, i the word inside it
   function automatic logic [31:0] rand_addr(region_e r, int m, int k, int i);
      case (r)
         REG_BIOS:  return pick3(m, BIOS_BASE_0, BIOS_BASE_1, BIOS_BASE_2) + k * 64 + i * 4;
         REG_MAIN:  return pick3(m, MAIN_BASE_0, MAIN_BASE_1, MAIN_BASE_2) +
                           (k % 128) * 32'h4000 + i * 4;
         REG_SCPAD: return ((m % 2) ? SCPAD_BASE_1 : SCPAD_BASE_0) + i * 4;
         REG_HWREG: return (m == 3) ? MEM_CTRL_3 :
                           pick3(m, HWREG_BASE_0, HWREG_BASE_1, HWREG_BASE_2) +
                           (k % 128) * 64 + i * 4;
         default:   return pick3(m, 32'h1F00_0000, 32'h1F80_3000, 32'hC000_0000) + i * 4;
      endcase
   endfunction

   task automatic check_val(string name, logic [31:0] exp, logic [31:0] act);
      if (act !== exp) begin
         $display("ERR %s expected %h actual %h", name, exp, act);
         $display("TESTS FAILED");
         $fatal(1);
      end
   endtask

   // one full four-phase cycle, called right after a rising edge
   task automatic access(string name, logic [31:0] a, logic [31:0] d, logic wr);
      cpu_req <= '{addr: a, wdata: d, ren: !wr, wen: wr};
      if (!wr) begin
         exp_name = name;
         exp_data <= ref_read(a);
         exp_pend <= 1'b1;
      end
      do @(posedge clk); while (!ack);
      cpu_req.ren <= 1'b0;
      cpu_req.wen <= 1'b0;
      if (wr) begin
         ref_write(a, d);
      end
      @(posedge clk);
      @(posedge clk);
      check_val({name, " ack release"}, 32'h0, 32'(ack));  // one cycle after release
   endtask

   always @(posedge clk) begin
      if (exp_pend && ack) begin
         check_val(exp_name, exp_data, rdata);
         exp_pend <= 1'b0;
      end
   end

   initial begin
      #(N_ACCESS * 40 * CLK_PERIOD);
      $display("watchdog expired before all accesses completed");
      $display("TESTS FAILED");
      $fatal(1);
   end

   initial begin
      logic [31:0] a;
      region_e     r;
      int          m;
      void'($urandom(68));
      clk       = 1'b0;
      rst       = 1'b1;
      cpu_req   = '0;
      exp_name  = "";
      exp_data  = '0;
      exp_pend  = 1'b0;
      $readmemh("bios.hex", bios_m);
      for (int i = 0; i < HWREG_WORDS; i++) begin
         hw_m[i] = '0;  // registers clear on reset
      end
      repeat (2) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);

      for (int i = 0; i < 16; i++) begin
         access($sformatf("bios rd %0d", i),
                pick3(i, BIOS_BASE_0, BIOS_BASE_1, BIOS_BASE_2) + i * 32'h44, '0, 1'b0);
      end
      access("bios wr", BIOS_BASE_2 + 32'h8, 32'hDEAD_BEEF, 1'b1);
      access("bios rd after wr", BIOS_BASE_0 + 32'h8, '0, 1'b0);
      access("bios wr alias", BIOS_BASE_1 + 32'h7_FFFC, 32'h1234_5678, 1'b1);
      access("bios rd after alias wr", BIOS_BASE_2 + 32'h3C, '0, 1'b0);

      for (int i = 0; i < 16; i++) begin
         access($sformatf("main wr %0d", i),
                pick3(i, MAIN_BASE_0, MAIN_BASE_1, MAIN_BASE_2) + i * 4, $urandom, 1'b1);
      end
      for (int i = 0; i < 16; i++) begin
         access($sformatf("main rd %0d", i),
                pick3(i + 2, MAIN_BASE_0, MAIN_BASE_1, MAIN_BASE_2) + i * 32'h4004, '0, 1'b0);
      end
      access("main wr alias", MAIN_BASE_0 + 32'h1F_C000, 32'h5A5A_0F0F, 1'b1);
      access("main rd alias", MAIN_BASE_1, '0, 1'b0);

      for (int i = 0; i < 16; i++) begin
         access($sformatf("scpad wr %0d", i),
                ((i % 2) ? SCPAD_BASE_1 : SCPAD_BASE_0) + i * 4, $urandom, 1'b1);
      end
      for (int i = 0; i < 16; i++) begin
         access($sformatf("scpad rd %0d", i),
                ((i % 2) ? SCPAD_BASE_0 : SCPAD_BASE_1) + i * 4, '0, 1'b0);
      end
      access("scpad wr top", SCPAD_BASE_0 + 32'h3FC, 32'hC0DE_00FF, 1'b1);
      access("scpad rd top", SCPAD_BASE_1 + 32'h3FC, '0, 1'b0);

      for (int i = 0; i < 16; i++) begin
         access($sformatf("hwreg wr %0d", i),
                pick3(i, HWREG_BASE_0, HWREG_BASE_1, HWREG_BASE_2) + i * 32'h44, $urandom, 1'b1);
      end
      for (int i = 0; i < 16; i++) begin
         access($sformatf("hwreg rd %0d", i),
                pick3(i + 1, HWREG_BASE_0, HWREG_BASE_1, HWREG_BASE_2) + i * 4, '0, 1'b0);
      end
      access("mem ctrl 3 wr", MEM_CTRL_3, 32'h0000_0B88, 1'b1);  // lands in register 12
      access("hwreg rd 12", HWREG_BASE_0 + 32'h30, '0, 1'b0);
      access("mem ctrl 3 rd", MEM_CTRL_3, '0, 1'b0);

      access("unmapped rd pport", 32'h1F00_0000, '0, 1'b0);
      access("unmapped rd pport 2", 32'h1F00_0010, '0, 1'b0);
      access("unmapped rd scpad gap", 32'h1F80_0400, '0, 1'b0);
      access("unmapped rd hw end", 32'h1F80_3000, '0, 1'b0);
      access("unmapped rd kseg2", 32'hC000_0000, '0, 1'b0);
      access("unmapped wr main end", MAIN_SIZE, 32'hFFFF_FFFF, 1'b1);
      access("unmapped wr scpad gap", 32'h1F80_0400, 32'hFFFF_FFFF, 1'b1);
      access("unmapped wr hw end", 32'h1F80_3000, 32'hFFFF_FFFF, 1'b1);
      access("main rd after unmapped wr", MAIN_BASE_2, '0, 1'b0);
      access("scpad rd after unmapped wr", SCPAD_BASE_0, '0, 1'b0);
      access("hwreg rd after unmapped wr", HWREG_BASE_1, '0, 1'b0);

      // indices stay below 16 so every read hits written words
      for (int n = 0; n < N_RANDOM; n++) begin
         r = region_e'($urandom_range(0, 4));
         m = $urandom_range(0, 3);
         a = rand_addr(r, m, $urandom_range(0, 8191), $urandom_range(0, 15));
         access($sformatf("rand %0d", n), a, $urandom, 1'($urandom_range(0, 1)));
      end

      $display("TESTS PASSED");
      $finish;
   end

endmodule

// File: mem_system.sv
`timescale 1ns/1ps

module mem_system (
   input  logic                  clk,
   input  logic                  rst,
   input  mem_map_pkg::cpu_req_t cpu_i,
   output logic                  ack_o,
   output logic [31:0]           rdata_o
);
   import mem_map_pkg::*;

   logic [BIOS_AW-1:0] bios_idx;
   logic [31:0]        bios_data;
   mem_req_t           ram_req;
   mem_req_t           scpad_req;
   mem_req_t           hw_req;
   logic               ram_waitrq;
   logic               ram_rvalid;
   logic [31:0]        ram_rdata;
   logic [31:0]        scpad_rdata;
   logic               hw_ack;
   logic [31:0]        hw_rdata;

   bus_decoder dec0 (
      .clk           (clk),
      .rst           (rst),
      .cpu_i         (cpu_i),
      .ack_o         (ack_o),
      .rdata_o       (rdata_o),
      .bios_idx_o    (bios_idx),
      .bios_data_i   (bios_data),
      .ram_req_o     (ram_req),
      .ram_waitrq_i  (ram_waitrq),
      .ram_rvalid_i  (ram_rvalid),
      .ram_rdata_i   (ram_rdata),
      .scpad_req_o   (scpad_req),
      .scpad_rdata_i (scpad_rdata),
      .hw_req_o      (hw_req),
      .hw_ack_i      (hw_ack),
      .hw_rdata_i    (hw_rdata)
   );

   bios_rom bios0 (
      .clk    (clk),
      .idx_i  (bios_idx),
      .data_o (bios_data)
   );

   main_ram ram0 (
      .clk      (clk),
      .rst      (rst),
      .req_i    (ram_req),
      .waitrq_o (ram_waitrq),
      .rvalid_o (ram_rvalid),
      .rdata_o  (ram_rdata)
   );

   scratch_pad scpad0 (
      .clk     (clk),
      .req_i   (scpad_req),
      .rdata_o (scpad_rdata)
   );

   hw_regs hw0 (
      .clk     (clk),
      .rst     (rst),
      .req_i   (hw_req),
      .ack_o   (hw_ack),
      .rdata_o (hw_rdata)
   );

endmodule

// File: bus_decoder.sv
`timescale 1ns/1ps

module bus_decoder (
   input  logic                            clk,
   input  logic                            rst,
   input  mem_map_pkg::cpu_req_t           cpu_i,
   output logic                            ack_o,
   output logic [31:0]                     rdata_o,
   output logic [mem_map_pkg::BIOS_AW-1:0] bios_idx_o,
   input  logic [31:0]                     bios_data_i,
   output mem_map_pkg::mem_req_t           ram_req_o,
   input  logic                            ram_waitrq_i,
   input  logic                            ram_rvalid_i,
   input  logic [31:0]                     ram_rdata_i,
   output mem_map_pkg::mem_req_t           scpad_req_o,
   input  logic [31:0]                     scpad_rdata_i,
   output mem_map_pkg::mem_req_t           hw_req_o,
   input  logic                            hw_ack_i,
   input  logic [31:0]                     hw_rdata_i
);
   import mem_map_pkg::*;

   typedef enum logic [6:0] {
      IDLE      = 7'b0000001,
      READ      = 7'b0000010,
      READ_ACK  = 7'b0000100,
      LATCH     = 7'b0001000,
      WRITE     = 7'b0010000,
      WRITE_ACK = 7'b0100000,
      WAIT      = 7'b1000000
   } state_e;

   state_e   state, state_nxt;
   logic     ack_nxt;
   region_e  region;
   mem_req_t base_req;

   // unsigned wrap makes addresses below base fall outside
   function automatic logic in_win(logic [31:0] addr, logic [31:0] base, logic [31:0] size);
      return (addr - base) < size;
   endfunction

   always_comb begin
      if (in_win(cpu_i.addr, BIOS_BASE_0, BIOS_SIZE) ||
          in_win(cpu_i.addr, BIOS_BASE_1, BIOS_SIZE) ||
          in_win(cpu_i.addr, BIOS_BASE_2, BIOS_SIZE)) begin
         region = REG_BIOS;
      end else if (in_win(cpu_i.addr, MAIN_BASE_0, MAIN_SIZE) ||
                   in_win(cpu_i.addr, MAIN_BASE_1, MAIN_SIZE) ||
                   in_win(cpu_i.addr, MAIN_BASE_2, MAIN_SIZE)) begin
         region = REG_MAIN;
      end else if (in_win(cpu_i.addr, SCPAD_BASE_0, SCPAD_SIZE) ||
                   in_win(cpu_i.addr, SCPAD_BASE_1, SCPAD_SIZE)) begin
         region = REG_SCPAD;
      end else if (in_win(cpu_i.addr, HWREG_BASE_0, HWREG_SIZE) ||
                   in_win(cpu_i.addr, HWREG_BASE_1, HWREG_SIZE) ||
                   in_win(cpu_i.addr, HWREG_BASE_2, HWREG_SIZE) ||
                   (cpu_i.addr == MEM_CTRL_3)) begin
         region = REG_HWREG;
      end else begin
         region = REG_NONE;  // includes parallel port
      end
   end

   assign bios_idx_o     = cpu_i.addr[BIOS_AW+1:2];
   assign base_req.idx   = cpu_i.addr[IDX_W+1:2];
   assign base_req.wdata = cpu_i.wdata;
   assign base_req.ren   = 1'b0;
   assign base_req.wen   = 1'b0;

   always_comb begin
      state_nxt   = state;
      ack_nxt     = ack_o;
      ram_req_o   = base_req;
      scpad_req_o = base_req;
      hw_req_o    = base_req;
      case (state)
         IDLE: begin
            if (cpu_i.ren) begin
               state_nxt = READ;
            end else if (cpu_i.wen) begin
               state_nxt = WRITE;
            end
         end
         READ: begin
            case (region)
               REG_MAIN: begin
                  ram_req_o.ren = 1'b1;  // held through wait-request
                  if (!ram_waitrq_i) begin
                     state_nxt = LATCH;
                  end
               end
               REG_HWREG: begin
                  hw_req_o.ren = 1'b1;
                  state_nxt    = READ_ACK;
               end
               REG_SCPAD: begin
                  scpad_req_o.ren = 1'b1;
                  state_nxt       = LATCH;
               end
               default: begin
                  state_nxt = LATCH;  // bios data already on its way
               end
            endcase
         end
         READ_ACK: begin
            hw_req_o.ren = ~hw_ack_i;
            if (hw_ack_i) begin
               state_nxt = LATCH;
            end
         end
         LATCH: begin
            if (region != REG_MAIN || ram_rvalid_i) begin
               state_nxt = WAIT;
               ack_nxt   = 1'b1;
            end
         end
         WRITE: begin
            case (region)
               REG_MAIN: begin
                  ram_req_o.wen = 1'b1;
                  if (!ram_waitrq_i) begin
                     state_nxt = WRITE_ACK;
                  end
               end
               REG_HWREG: begin
                  hw_req_o.wen = 1'b1;
                  state_nxt    = WRITE_ACK;
               end
               REG_SCPAD: begin
                  scpad_req_o.wen = 1'b1;
                  state_nxt       = WAIT;
                  ack_nxt         = 1'b1;
               end
               default: begin
                  state_nxt = WAIT;  // rom and unmapped writes are dropped
                  ack_nxt   = 1'b1;
               end
            endcase
         end
         WRITE_ACK: begin
            if (region == REG_HWREG) begin
               hw_req_o.wen = ~hw_ack_i;
               if (hw_ack_i) begin
                  state_nxt = WAIT;
                  ack_nxt   = 1'b1;
               end
            end else begin
               state_nxt = WAIT;
               ack_nxt   = 1'b1;
            end
         end
         WAIT: begin
            if (!cpu_i.ren && !cpu_i.wen) begin
               state_nxt = IDLE;
               ack_nxt   = 1'b0;
            end
         end
         default: begin
            state_nxt = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         state <= IDLE;
         ack_o <= 1'b0;
      end else begin
         state <= state_nxt;
         ack_o <= ack_nxt;
      end
   end

   always_ff @(posedge clk) begin
      if (state == LATCH) begin
         case (region)
            REG_BIOS:  rdata_o <= bios_data_i;
            REG_MAIN:  rdata_o <= ram_rdata_i;  // last write lands with rvalid
            REG_SCPAD: rdata_o <= scpad_rdata_i;
            REG_HWREG: rdata_o <= hw_rdata_i;
            default:   rdata_o <= '0;
         endcase
      end
   end

   assert property (@(posedge clk) disable iff (rst)
      !(ram_req_o.ren && ram_req_o.wen));

   // cpu must hold the address until it sees ack
   assert property (@(posedge clk) disable iff (rst)
      (cpu_i.ren || cpu_i.wen) && !ack_o |=> $stable(cpu_i.addr));

endmodule

// File: hw_regs.sv
`timescale 1ns/1ps

module hw_regs (
   input  logic                  clk,
   input  logic                  rst,
   input  mem_map_pkg::mem_req_t req_i,
   output logic                  ack_o,
   output logic [31:0]           rdata_o
);
   import mem_map_pkg::*;

   logic [31:0]         regs [HWREG_WORDS];
   logic                pend;
   logic                req_act;
   logic                first;
   logic [HWREG_AW-1:0] sel;

   assign req_act = req_i.ren | req_i.wen;
   assign first   = req_act & ~pend;  // new request this cycle
   assign sel     = req_i.idx[HWREG_AW-1:0];

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         pend  <= 1'b0;
         ack_o <= 1'b0;
         for (int i = 0; i < HWREG_WORDS; i++) begin
            regs[i] <= '0;
         end
      end else begin
         pend  <= req_act;
         ack_o <= first;
         if (first && req_i.wen) begin
            regs[sel] <= req_i.wdata;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (first && req_i.ren) begin
         rdata_o <= regs[sel];  // holds after the ack
      end
   end

   assert property (@(posedge clk) disable iff (rst)
      ack_o |=> !ack_o);

endmodule

// File: scratch_pad.sv
`timescale 1ns/1ps

module scratch_pad (
   input  logic                  clk,
   input  mem_map_pkg::mem_req_t req_i,
   output logic [31:0]           rdata_o
);
   import mem_map_pkg::*;

   logic [31:0] mem [SCPAD_WORDS];

   always_ff @(posedge clk) begin
      if (req_i.wen) begin
         mem[req_i.idx[SCPAD_AW-1:0]] <= req_i.wdata;  // aliases mod depth
      end
      if (req_i.ren) begin
         rdata_o <= mem[req_i.idx[SCPAD_AW-1:0]];
      end
   end

endmodule

// File: main_ram.sv
`timescale 1ns/1ps

module main_ram (
   input  logic                  clk,
   input  logic                  rst,
   input  mem_map_pkg::mem_req_t req_i,
   output logic                  waitrq_o,
   output logic                  rvalid_o,
   output logic [31:0]           rdata_o
);
   import mem_map_pkg::*;

   logic [31:0]                mem [MAIN_WORDS];
   logic [MAIN_BUSY_W-1:0]     busy_cnt;
   logic [MAIN_RD_LATENCY-1:0] rd_vld;
   logic [31:0]                rd_data [MAIN_RD_LATENCY];
   logic                       accept;

   assign waitrq_o = (busy_cnt != '0);
   assign accept   = (req_i.ren | req_i.wen) & ~waitrq_o;

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         busy_cnt <= '0;
      end else if (accept) begin
         busy_cnt <= MAIN_BUSY_W'(MAIN_BUSY_CYCLES);
      end else if (busy_cnt != '0) begin
         busy_cnt <= busy_cnt - 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (accept && req_i.wen) begin
         mem[req_i.idx] <= req_i.wdata;
      end
      rd_data[0] <= mem[req_i.idx];
   end

   always_ff @(posedge clk) begin
      for (int i = 1; i < MAIN_RD_LATENCY; i++) begin
         rd_data[i] <= rd_data[i-1];  // data rides alongside rd_vld
      end
   end

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         rd_vld <= '0;
      end else begin
         rd_vld <= {rd_vld[MAIN_RD_LATENCY-2:0], accept & req_i.ren};
      end
   end

   assign rvalid_o = rd_vld[MAIN_RD_LATENCY-1];
   assign rdata_o  = rd_data[MAIN_RD_LATENCY-1];

   // busy window after each accept, nothing taken inside it
   assert property (@(posedge clk) disable iff (rst)
      accept |=> (waitrq_o && !accept) [*MAIN_BUSY_CYCLES] ##1 !waitrq_o);

endmodule

// File: bios_rom.sv
`timescale 1ns/1ps

module bios_rom (
   input  logic                            clk,
   input  logic [mem_map_pkg::BIOS_AW-1:0] idx_i,
   output logic [31:0]                     data_o
);
   import mem_map_pkg::*;

   logic [31:0] rom [BIOS_WORDS];

   initial begin
      $readmemh("bios.hex", rom);
   end

   always_ff @(posedge clk) begin
      data_o <= rom[idx_i];  // one cycle read
   end

endmodule

// File: mem_map_pkg.sv
package mem_map_pkg;

   // system memory map, with KUSEG / KSEG0 / KSEG1 mirrors
   localparam logic [31:0] BIOS_BASE_0  = 32'h1FC0_0000;
   localparam logic [31:0] BIOS_BASE_1  = 32'h9FC0_0000;
   localparam logic [31:0] BIOS_BASE_2  = 32'hBFC0_0000;
   localparam logic [31:0] BIOS_SIZE    = 32'h0008_0000;

   localparam logic [31:0] MAIN_BASE_0  = 32'h0000_0000;  // kuseg
   localparam logic [31:0] MAIN_BASE_1  = 32'h8000_0000;  // kseg0
   localparam logic [31:0] MAIN_BASE_2  = 32'hA000_0000;  // kseg1
   localparam logic [31:0] MAIN_SIZE    = 32'h0020_0000;

   localparam logic [31:0] SCPAD_BASE_0 = 32'h1F80_0000;
   localparam logic [31:0] SCPAD_BASE_1 = 32'h9F80_0000;
   localparam logic [31:0] SCPAD_SIZE   = 32'h0000_0400;

   localparam logic [31:0] HWREG_BASE_0 = 32'h1F80_1000;
   localparam logic [31:0] HWREG_BASE_1 = 32'h9F80_1000;
   localparam logic [31:0] HWREG_BASE_2 = 32'hBF80_1000;
   localparam logic [31:0] HWREG_SIZE   = 32'h0000_2000;
   localparam logic [31:0] MEM_CTRL_3   = 32'hFFFE_0130;  // lone alias into hw regs

   // target depths in 32-bit words
   localparam int BIOS_WORDS  = 16;
   localparam int MAIN_WORDS  = 4096;
   localparam int SCPAD_WORDS = 256;
   localparam int HWREG_WORDS = 16;

   localparam int BIOS_AW  = $clog2(BIOS_WORDS);
   localparam int IDX_W    = $clog2(MAIN_WORDS);  // widest target index
   localparam int SCPAD_AW = $clog2(SCPAD_WORDS);
   localparam int HWREG_AW = $clog2(HWREG_WORDS);

   localparam int MAIN_RD_LATENCY  = 3;
   localparam int MAIN_BUSY_CYCLES = 2;
   localparam int MAIN_BUSY_W      = $clog2(MAIN_BUSY_CYCLES + 1);

   typedef enum logic [2:0] {
      REG_BIOS,
      REG_MAIN,
      REG_SCPAD,
      REG_HWREG,
      REG_NONE
   } region_e;

   typedef struct packed {
      logic [31:0] addr;
      logic [31:0] wdata;
      logic        ren;
      logic        wen;
   } cpu_req_t;

   typedef struct packed {
      logic [IDX_W-1:0] idx;  // word index
      logic [31:0]      wdata;
      logic             ren;
      logic             wen;
   } mem_req_t;

endpackage
